// File: src/pmp_pkg.sv
package pmp_pkg;

    // ============================================================
    // Sizes and CSR map
    // ============================================================

    localparam int unsigned PMP_ENTRIES   = 8;
    localparam int unsigned PMP_CFG_WORDS = PMP_ENTRIES / 4;
    localparam int unsigned BLOCK_ADDR_W  = 25;

    localparam logic [11:0] CSR_PMPCFG_BASE  = 12'h3A0;
    localparam logic [11:0] CSR_PMPADDR_BASE = 12'h3B0;

    // A field encodings of the one supported mode
    localparam logic [1:0] CFG_A_OFF   = 2'b00;
    localparam logic [1:0] CFG_A_NAPOT = 2'b11;

    // pmpaddr bits 4:0 as seen on readback
    localparam logic [4:0] NAPOT_LOW = 5'b01111;

    // ============================================================
    // CSR word layouts
    // ============================================================

    // Architectural pmpcfg byte
    typedef struct packed {
        logic       lock;
        logic [1:0] rsvd;
        logic [1:0] a;
        logic       x;
        logic       w;
        logic       r;
    } pmp_cfg_t;

    // Bits 29:5 of a pmpaddr word hold the block-address part
    typedef struct packed {
        logic [1:0]              hi;
        logic [BLOCK_ADDR_W-1:0] napot;
        logic [4:0]              low;
    } pmp_addr_word_t;

    // One CSR data word read as cfg bytes or as an address
    typedef union packed {
        pmp_cfg_t [3:0] cfg;
        pmp_addr_word_t addr;
    } pmp_csr_word_u;

    // ============================================================
    // Entry storage and ports
    // ============================================================

    typedef struct packed {
        logic                    enabled;
        logic                    lock;
        logic                    x;
        logic                    w;
        logic                    r;
        logic [BLOCK_ADDR_W-1:0] addr;
        logic [BLOCK_ADDR_W-1:0] mask;
        logic [BLOCK_ADDR_W-1:0] match;
    } pmp_entry_t;

    typedef struct packed {
        logic [11:0] address;
        logic [31:0] wdata;
        logic        wr_en;
    } pmp_csr_req_t;

    typedef struct packed {
        logic [BLOCK_ADDR_W-1:0] addr;
        logic                    mmode;
    } pmp_fetch_t;

    typedef struct packed {
        logic [BLOCK_ADDR_W-1:0] addr;
        logic                    mmode;
        logic                    write;
    } pmp_data_t;

endpackage

// File: src/pmp_napot_decode.sv
`timescale 1ns/1ps

module pmp_napot_decode (
    input  logic [pmp_pkg::BLOCK_ADDR_W-1:0] napot_i,
    output logic [pmp_pkg::BLOCK_ADDR_W-1:0] mask_o,
    output logic [pmp_pkg::BLOCK_ADDR_W-1:0] match_o
);

    // ============================================================
    // Trailing-ones run
    // ============================================================

    // ones_run[i] is set when napot_i[i:0] are all ones
    logic [pmp_pkg::BLOCK_ADDR_W-1:0] ones_run;

    always_comb begin
        ones_run[0] = napot_i[0];
        for (int i = 1; i < pmp_pkg::BLOCK_ADDR_W; i++) begin
            ones_run[i] = ones_run[i-1] & napot_i[i];
        end
    end

    // ============================================================
    // Compare mask and match value
    // ============================================================

    // Bits inside the run are don't-care for the compare,
    // so each extra trailing one doubles the region
    assign mask_o = ~ones_run;

    // Run bits cleared so the checker compares with a plain AND
    assign match_o = napot_i & mask_o;

endmodule

// File: src/pmp_csr_bank.sv
`timescale 1ns/1ps

module pmp_csr_bank (
    input  logic                                               core_clock_i,
    input  logic                                               rst_n_i,

    input  pmp_pkg::pmp_csr_req_t                              csr_req_i,
    output logic [31:0]                                        csr_rdata_o,
    output logic                                               csr_exists_o,

    // NAPOT decoder runs on the incoming write data
    output logic [pmp_pkg::BLOCK_ADDR_W-1:0]                   napot_o,
    input  logic [pmp_pkg::BLOCK_ADDR_W-1:0]                   mask_i,
    input  logic [pmp_pkg::BLOCK_ADDR_W-1:0]                   match_i,

    output pmp_pkg::pmp_entry_t [pmp_pkg::PMP_ENTRIES-1:0]     entries_o
);

    pmp_pkg::pmp_entry_t [pmp_pkg::PMP_ENTRIES-1:0] entries_q;

    pmp_pkg::pmp_csr_word_u wr_word;
    pmp_pkg::pmp_csr_word_u rd_word;

    logic [11:0] cfg_offset;
    logic [11:0] addr_offset;
    logic        cfg_hit;
    logic        addr_hit;

    // ============================================================
    // Address decode
    // ============================================================

    assign cfg_offset  = csr_req_i.address - pmp_pkg::CSR_PMPCFG_BASE;
    assign addr_offset = csr_req_i.address - pmp_pkg::CSR_PMPADDR_BASE;

    // Offsets wrap on addresses below the base, so one compare is enough
    assign cfg_hit  = cfg_offset < 12'(pmp_pkg::PMP_CFG_WORDS);
    assign addr_hit = addr_offset < 12'(pmp_pkg::PMP_ENTRIES);

    assign csr_exists_o = cfg_hit | addr_hit;

    // ============================================================
    // CSR write
    // ============================================================

    assign wr_word = csr_req_i.wdata;
    assign napot_o = wr_word.addr.napot;

    always_ff @(posedge core_clock_i) begin
        if (!rst_n_i) begin
            entries_q <= '0;
        end else if (csr_req_i.wr_en) begin
            for (int e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin
                // Locked entries hold until reset
                if (!entries_q[e].lock) begin
                    // Four entries share one pmpcfg word
                    if (cfg_hit && (cfg_offset == 12'(e / 4))) begin
                        entries_q[e].enabled <=
                            (wr_word.cfg[e % 4].a == pmp_pkg::CFG_A_NAPOT);
                        entries_q[e].lock <= wr_word.cfg[e % 4].lock;
                        entries_q[e].x    <= wr_word.cfg[e % 4].x;
                        entries_q[e].w    <= wr_word.cfg[e % 4].w;
                        entries_q[e].r    <= wr_word.cfg[e % 4].r;
                    end

                    if (addr_hit && (addr_offset == 12'(e))) begin
                        entries_q[e].addr  <= wr_word.addr.napot;
                        entries_q[e].mask  <= mask_i;
                        entries_q[e].match <= match_i;
                    end
                end
            end
        end
    end

    // ============================================================
    // CSR readback
    // ============================================================

    always_comb begin
        rd_word = '0;

        for (int e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin
            if (cfg_hit && (cfg_offset == 12'(e / 4))) begin
                rd_word.cfg[e % 4].lock = entries_q[e].lock;
                rd_word.cfg[e % 4].a    = entries_q[e].enabled ? pmp_pkg::CFG_A_NAPOT
                                                               : pmp_pkg::CFG_A_OFF;
                rd_word.cfg[e % 4].x    = entries_q[e].x;
                rd_word.cfg[e % 4].w    = entries_q[e].w;
                rd_word.cfg[e % 4].r    = entries_q[e].r;
            end
        end

        if (addr_hit) begin
            // Granule bits below the stored field read as 0_1111
            rd_word.addr.low = pmp_pkg::NAPOT_LOW;
            for (int e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin
                if (addr_offset == 12'(e)) begin
                    rd_word.addr.napot = entries_q[e].addr;
                end
            end
        end
    end

    assign csr_rdata_o = rd_word;

    assign entries_o = entries_q;

endmodule

// File: src/pmp_checker.sv
`timescale 1ns/1ps

module pmp_checker (
    input  pmp_pkg::pmp_entry_t [pmp_pkg::PMP_ENTRIES-1:0] entries_i,

    input  pmp_pkg::pmp_fetch_t                            fetch_i,
    output logic                                           fetch_kill_o,

    input  pmp_pkg::pmp_data_t                             data_i,
    output logic                                           data_kill_o
);

    // ============================================================
    // Shared helpers
    // ============================================================

    // Lowest-index enabled entry whose region holds addr
    function automatic logic find_entry(
        input  pmp_pkg::pmp_entry_t [pmp_pkg::PMP_ENTRIES-1:0] ents,
        input  logic [pmp_pkg::BLOCK_ADDR_W-1:0]               addr,
        output pmp_pkg::pmp_entry_t                            hit_entry
    );
        logic found;
        found     = 1'b0;
        hit_entry = '0;
        for (int i = 0; i < pmp_pkg::PMP_ENTRIES; i++) begin
            if (!found && ents[i].enabled && ((addr & ents[i].mask) == ents[i].match)) begin
                found     = 1'b1;
                hit_entry = ents[i];
            end
        end
        return found;
    endfunction

    // Machine mode only checks locked entries
    function automatic logic kill_rule(
        input logic mmode,
        input logic hit,
        input logic lock,
        input logic perm
    );
        if (mmode) begin
            return hit & lock & ~perm;
        end
        return ~hit | ~perm;
    endfunction

    // ============================================================
    // Fetch and data lookups
    // ============================================================

    pmp_pkg::pmp_entry_t fetch_ent;
    pmp_pkg::pmp_entry_t data_ent;
    logic                fetch_hit;
    logic                data_hit;
    logic                data_perm;

    always_comb begin
        fetch_hit = find_entry(entries_i, fetch_i.addr, fetch_ent);
        data_hit  = find_entry(entries_i, data_i.addr, data_ent);
        data_perm = data_i.write ? data_ent.w : data_ent.r;
    end

    assign fetch_kill_o = kill_rule(fetch_i.mmode, fetch_hit, fetch_ent.lock, fetch_ent.x);
    assign data_kill_o  = kill_rule(data_i.mmode, data_hit, data_ent.lock, data_perm);

endmodule

// File: src/pmp_unit.sv
`timescale 1ns/1ps

module pmp_unit (
    input  logic                  core_clock_i,
    input  logic                  rst_n_i,

    // CSR port
    input  pmp_pkg::pmp_csr_req_t csr_req_i,
    output logic [31:0]           csr_rdata_o,
    output logic                  csr_exists_o,

    // Fetch stage
    input  pmp_pkg::pmp_fetch_t   fetch_i,
    output logic                  fetch_kill_o,

    // Memory stage
    input  pmp_pkg::pmp_data_t    data_i,
    output logic                  data_kill_o
);

    logic [pmp_pkg::BLOCK_ADDR_W-1:0] napot;
    logic [pmp_pkg::BLOCK_ADDR_W-1:0] mask;
    logic [pmp_pkg::BLOCK_ADDR_W-1:0] match;

    pmp_pkg::pmp_entry_t [pmp_pkg::PMP_ENTRIES-1:0] entries;

    // ============================================================
    // Entry storage and CSR access
    // ============================================================

    pmp_csr_bank pmp_csr_bank_inst (
        .core_clock_i (core_clock_i),
        .rst_n_i      (rst_n_i),
        .csr_req_i    (csr_req_i),
        .csr_rdata_o  (csr_rdata_o),
        .csr_exists_o (csr_exists_o),
        .napot_o      (napot),
        .mask_i       (mask),
        .match_i      (match),
        .entries_o    (entries)
    );

    // Region decode done once at write time
    pmp_napot_decode pmp_napot_decode_inst (
        .napot_i (napot),
        .mask_o  (mask),
        .match_o (match)
    );

    // ============================================================
    // Access checks
    // ============================================================

    pmp_checker pmp_checker_inst (
        .entries_i    (entries),
        .fetch_i      (fetch_i),
        .fetch_kill_o (fetch_kill_o),
        .data_i       (data_i),
        .data_kill_o  (data_kill_o)
    );

endmodule

// File: verif/pmp_tb_model.svh
`ifndef PMP_TB_MODEL_SVH
`define PMP_TB_MODEL_SVH

// ============================================================
// Reference model of the entries and kill rules
// ============================================================

logic [31:0]         lfsr_state = 32'hc982ffec;
pmp_pkg::pmp_entry_t model_ents [pmp_pkg::PMP_ENTRIES];

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lsb        = lfsr_state[0];
        r          = {r[30:0], lsb};
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
    end
    return r;
endfunction

function automatic void model_reset();
    for (int e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin
        model_ents[e] = '0;
    end
endfunction

// Region of a napot field counted bit by bit
function automatic void model_napot(
    input  logic [pmp_pkg::BLOCK_ADDR_W-1:0] napot,
    output logic [pmp_pkg::BLOCK_ADDR_W-1:0] mask,
    output logic [pmp_pkg::BLOCK_ADDR_W-1:0] match
);
    int   ones;
    logic done;
    ones = 0;
    done = 1'b0;
    for (int i = 0; i < pmp_pkg::BLOCK_ADDR_W; i++) begin
        if (napot[i] && !done) begin
            ones++;
        end else begin
            done = 1'b1;
        end
    end
    mask = '1;
    for (int i = 0; i < ones; i++) begin
        mask[i] = 1'b0;
    end
    match = napot & mask;
endfunction

function automatic int cfg_index(input logic [11:0] addr);
    return int'(addr) - int'(pmp_pkg::CSR_PMPCFG_BASE);
endfunction

function automatic int addr_index(input logic [11:0] addr);
    return int'(addr) - int'(pmp_pkg::CSR_PMPADDR_BASE);
endfunction

function automatic logic model_exists(input logic [11:0] addr);
    return (cfg_index(addr) >= 0 && cfg_index(addr) < int'(pmp_pkg::PMP_CFG_WORDS)) ||
           (addr_index(addr) >= 0 && addr_index(addr) < int'(pmp_pkg::PMP_ENTRIES));
endfunction

function automatic void model_write(input logic [11:0] addr, input logic [31:0] wdata);
    pmp_pkg::pmp_csr_word_u w;
    int                     c;
    int                     a;
    w = wdata;
    c = cfg_index(addr);
    a = addr_index(addr);
    if (c >= 0 && c < int'(pmp_pkg::PMP_CFG_WORDS)) begin
        for (int k = 0; k < 4; k++) begin
            if (!model_ents[c*4+k].lock) begin
                model_ents[c*4+k].enabled = (w.cfg[k].a == 2'b11);
                model_ents[c*4+k].lock    = w.cfg[k].lock;
                model_ents[c*4+k].x       = w.cfg[k].x;
                model_ents[c*4+k].w       = w.cfg[k].w;
                model_ents[c*4+k].r       = w.cfg[k].r;
            end
        end
    end else if (a >= 0 && a < int'(pmp_pkg::PMP_ENTRIES)) begin
        if (!model_ents[a].lock) begin
            model_ents[a].addr = w.addr.napot;
            model_napot(w.addr.napot, model_ents[a].mask, model_ents[a].match);
        end
    end
endfunction

function automatic logic [31:0] model_read(input logic [11:0] addr);
    pmp_pkg::pmp_csr_word_u w;
    int                     c;
    int                     a;
    w = '0;
    c = cfg_index(addr);
    a = addr_index(addr);
    if (c >= 0 && c < int'(pmp_pkg::PMP_CFG_WORDS)) begin
        for (int k = 0; k < 4; k++) begin
            w.cfg[k].lock = model_ents[c*4+k].lock;
            w.cfg[k].a    = model_ents[c*4+k].enabled ? 2'b11 : 2'b00;
            w.cfg[k].x    = model_ents[c*4+k].x;
            w.cfg[k].w    = model_ents[c*4+k].w;
            w.cfg[k].r    = model_ents[c*4+k].r;
        end
    end else if (a >= 0 && a < int'(pmp_pkg::PMP_ENTRIES)) begin
        w.addr.napot = model_ents[a].addr;
        w.addr.low   = 5'b01111;
    end
    return w;
endfunction

// Permission select 0 is x, 1 is w, 2 is r
function automatic logic model_kill(
    input logic [pmp_pkg::BLOCK_ADDR_W-1:0] addr,
    input logic                             mmode,
    input int                               perm_sel
);
    logic hit;
    logic perm;
    logic lock;
    hit  = 1'b0;
    perm = 1'b0;
    lock = 1'b0;
    for (int e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin
        if (!hit && model_ents[e].enabled &&
            ((addr & model_ents[e].mask) == model_ents[e].match)) begin
            hit  = 1'b1;
            lock = model_ents[e].lock;
            perm = (perm_sel == 0) ? model_ents[e].x :
                   (perm_sel == 1) ? model_ents[e].w : model_ents[e].r;
        end
    end
    if (mmode) begin
        return hit && lock && !perm;
    end
    return !hit || !perm;
endfunction

`endif

// File: verif/pmp_tb.sv
`timescale 1ns/1ps

module pmp_tb;

    localparam int MAX_CYCLES = 4000;

    logic                  core_clock = 1'b0;
    logic                  rst_n;
    pmp_pkg::pmp_csr_req_t csr_req;
    logic [31:0]           csr_rdata;
    logic                  csr_exists;
    pmp_pkg::pmp_fetch_t   fetch;
    logic                  fetch_kill;
    pmp_pkg::pmp_data_t    data;
    logic                  data_kill;

    int cycles      = 0;
    int test_errors = 0;
    int pass_count  = 0;
    int fail_count  = 0;

    `include "pmp_tb_model.svh"

    pmp_unit pmp_unit_inst (
        .core_clock_i (core_clock),
        .rst_n_i      (rst_n),
        .csr_req_i    (csr_req),
        .csr_rdata_o  (csr_rdata),
        .csr_exists_o (csr_exists),
        .fetch_i      (fetch),
        .fetch_kill_o (fetch_kill),
        .data_i       (data),
        .data_kill_o  (data_kill)
    );

    always #20 core_clock = ~core_clock;

    always @(posedge core_clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // ============================================================
    // Drive and check helpers
    // ============================================================

    task automatic tick();
        @(posedge core_clock);
        #1;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) tick();
        rst_n = 1'b1;
        model_reset();
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] wdata);
        csr_req.address = addr;
        csr_req.wdata   = wdata;
        csr_req.wr_en   = 1'b1;
        tick();
        csr_req.wr_en = 1'b0;
        model_write(addr, wdata);
    endtask

    task automatic check_read(input string name, input logic [11:0] addr);
        logic [31:0] exp;
        csr_req.address = addr;
        csr_req.wr_en   = 1'b0;
        #37;
        exp = model_read(addr);
        if (csr_rdata !== exp) begin
            $display("Error %s: csr %h expected %h, actual %h", name, addr, exp, csr_rdata);
            test_errors++;
        end
        if (csr_exists !== model_exists(addr)) begin
            $display("Error %s: exists of %h expected %b, actual %b",
                     name, addr, model_exists(addr), csr_exists);
            test_errors++;
        end
        tick();
    endtask

    task automatic check_access(
        input string                            name,
        input logic [pmp_pkg::BLOCK_ADDR_W-1:0] faddr,
        input logic                             fmode,
        input logic [pmp_pkg::BLOCK_ADDR_W-1:0] daddr,
        input logic                             dmode,
        input logic                             dwrite
    );
        logic exp_f;
        logic exp_d;
        fetch.addr = faddr;
        fetch.mmode = fmode;
        data.addr = daddr;
        data.mmode = dmode;
        data.write = dwrite;
        #37;
        exp_f = model_kill(faddr, fmode, 0);
        exp_d = model_kill(daddr, dmode, dwrite ? 1 : 2);
        if (fetch_kill !== exp_f) begin
            $display("Error %s: fetch kill at %h expected %b, actual %b",
                     name, faddr, exp_f, fetch_kill);
            test_errors++;
        end
        if (data_kill !== exp_d) begin
            $display("Error %s: data kill at %h expected %b, actual %b",
                     name, daddr, exp_d, data_kill);
            test_errors++;
        end
        tick();
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("%s: passed", name);
            pass_count++;
        end else begin
            $display("%s: %0d mismatches", name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    function automatic logic [11:0] csr_addr_of(input int idx);
        if (idx < 2) begin
            return pmp_pkg::CSR_PMPCFG_BASE + 12'(idx);
        end
        return pmp_pkg::CSR_PMPADDR_BASE + 12'(idx - 2);
    endfunction

    function automatic logic [pmp_pkg::BLOCK_ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = rand_bits(25);
        return r[24:0];
    endfunction

    // Random field with 0 to 7 trailing ones
    function automatic logic [31:0] rand_napot_word();
        logic [31:0] w;
        logic [31:0] r;
        int          k;
        w = rand_bits(32);
        r = rand_bits(3);
        k = int'(r);
        for (int i = 0; i < k; i++) begin
            w[5+i] = 1'b1;
        end
        w[5+k] = 1'b0;
        return w;
    endfunction

    function automatic logic [pmp_pkg::BLOCK_ADDR_W-1:0] addr_inside(input int e);
        return (rand_addr() & ~model_ents[e].mask) | model_ents[e].match;
    endfunction

    // ============================================================
    // Tests
    // ============================================================

    initial begin
        logic [31:0]                      r;
        logic [31:0]                      w;
        logic [11:0]                      a;
        logic [pmp_pkg::BLOCK_ADDR_W-1:0] base;
        logic [pmp_pkg::BLOCK_ADDR_W-1:0] fa;
        pmp_pkg::pmp_csr_word_u           cw;

        rst_n   = 1'b0;
        csr_req = '0;
        fetch   = '0;
        data    = '0;
        model_reset();
        apply_reset();

        for (int i = 0; i < 10; i++) begin
            check_read("reset_state", csr_addr_of(i));
        end
        for (int i = 0; i < 32; i++) begin
            r = rand_bits(2);
            check_access("reset_state", rand_addr(), r[0], rand_addr(), r[0], r[1]);
        end
        end_test("reset_state");

        for (int i = 0; i < 40; i++) begin
            r = rand_bits(4);
            a = (r < 10) ? csr_addr_of(int'(r)) : 12'(rand_bits(12));
            w = rand_bits(32);
            // No locks here so later writes still land
            if (a[11:4] == 8'h3A) begin
                w = w & 32'h7f7f7f7f;
            end
            csr_write(a, w);
            check_read("csr_readback", a);
        end
        end_test("csr_readback");

        for (int e = 0; e < 8; e++) begin
            csr_write(csr_addr_of(e + 2), rand_napot_word());
        end
        for (int c = 0; c < 2; c++) begin
            cw = '0;
            for (int k = 0; k < 4; k++) begin
                r = rand_bits(2);
                cw.cfg[k].a = r[0] ? 2'b11 : 2'b01;
                cw.cfg[k].x = r[1];
            end
            csr_write(csr_addr_of(c), cw);
        end
        for (int i = 0; i < 200; i++) begin
            r = rand_bits(3);
            fa = (i % 2 == 0) ? addr_inside(int'(r)) : rand_addr();
            check_access("napot_fetch", fa, 1'b0, fa, 1'b1, 1'b0);
        end
        end_test("napot_fetch");

        // Nested regions on one base where entry e spans 2^e blocks
        base = rand_addr();
        base[7:0] = '0;
        for (int e = 0; e < 8; e++) begin
            fa = base;
            for (int i = 0; i < e; i++) begin
                fa[i] = 1'b1;
            end
            fa[e] = 1'b0;
            csr_write(csr_addr_of(e + 2), {2'b00, fa, 5'b01111});
        end
        for (int c = 0; c < 2; c++) begin
            cw = '0;
            for (int k = 0; k < 4; k++) begin
                r = rand_bits(2);
                cw.cfg[k].a = 2'b11;
                cw.cfg[k].w = r[0];
                cw.cfg[k].r = r[1];
            end
            csr_write(csr_addr_of(c), cw);
        end
        for (int i = 0; i < 200; i++) begin
            fa = base;
            r = rand_bits(10);
            fa[7:0] = r[7:0];
            check_access("data_priority", fa, r[8], fa, r[8], r[9]);
        end
        end_test("data_priority");

        apply_reset();
        for (int e = 0; e < 8; e++) begin
            csr_write(csr_addr_of(e + 2), rand_napot_word());
        end
        for (int c = 0; c < 2; c++) begin
            cw = '0;
            for (int k = 0; k < 4; k++) begin
                r = rand_bits(3);
                cw.cfg[k].lock = (c == 0);
                cw.cfg[k].a    = 2'b11;
                cw.cfg[k].x    = (c == 1) & r[0];
                cw.cfg[k].w    = (c == 1) & r[1];
                cw.cfg[k].r    = r[2];
            end
            csr_write(csr_addr_of(c), cw);
        end
        for (int i = 0; i < 8; i++) begin
            csr_write(csr_addr_of(0), rand_bits(32));
            r = rand_bits(2);
            csr_write(csr_addr_of(int'(r) + 2), rand_napot_word());
            check_read("lock", csr_addr_of(0));
            check_read("lock", csr_addr_of(int'(r) + 2));
        end
        for (int i = 0; i < 40; i++) begin
            r = rand_bits(3);
            fa = addr_inside(int'(r[1:0]));
            check_access("lock", fa, 1'b1, fa, 1'b1, r[2]);
        end
        apply_reset();
        for (int i = 0; i < 10; i++) begin
            check_read("lock", csr_addr_of(i));
        end
        csr_write(csr_addr_of(0), rand_bits(32) & 32'h7f7f7f7f);
        check_read("lock", csr_addr_of(0));
        end_test("lock");

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+verif
src/pmp_pkg.sv
src/pmp_napot_decode.sv
src/pmp_csr_bank.sv
src/pmp_checker.sv
src/pmp_unit.sv
verif/pmp_tb.sv

// File: Makefile
TOP = pmp_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Everything OK" > /dev/null

clean:
	rm -rf obj_dir
